// ==== verilog/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

    localparam int XLEN       = 64;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ALU_CTRL_W = 5;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [ILEN-1:0]       inst_t;
    typedef logic [ALU_CTRL_W-1:0] alu_ctrl_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // ALU control words
    // Bits 2:0 pick the operation, bit 3 is the alternate form, bit 4 the word form
    localparam alu_ctrl_t ALU_ADD   = 5'b0_0000;
    localparam alu_ctrl_t ALU_SUB   = 5'b0_1000;
    localparam alu_ctrl_t ALU_SLL   = 5'b0_0001;
    localparam alu_ctrl_t ALU_SLT   = 5'b0_0010;  // Bit 1 forces the adder to subtract
    localparam alu_ctrl_t ALU_SLTU  = 5'b0_0011;
    localparam alu_ctrl_t ALU_XOR   = 5'b0_0100;
    localparam alu_ctrl_t ALU_SRL   = 5'b0_0101;
    localparam alu_ctrl_t ALU_SRA   = 5'b0_1101;
    localparam alu_ctrl_t ALU_OR    = 5'b0_0110;
    localparam alu_ctrl_t ALU_AND   = 5'b0_0111;
    localparam alu_ctrl_t ALU_PASSB = 5'b0_1111;  // And with all ones leaves operand b
    localparam alu_ctrl_t ALU_W_BIT = 5'b1_0000;

    // Major opcodes
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU,
        BR_JAL,
        BR_JALR
    } br_kind_e;

endpackage

`default_nettype wire

// ==== verilog/alu_adder.sv ====
`default_nettype none
`timescale 1ns/1ps

module alu_adder (
    input  exu_pkg::xlen_t a,
    input  exu_pkg::xlen_t b,
    input  logic           sub,
    output exu_pkg::xlen_t sum,
    output logic           carry,
    output logic           sign,
    output logic           overflow
);
    import exu_pkg::*;

    xlen_t b_in;
    logic  carry_62;
    logic  carry_63;

    always_comb begin
        b_in = sub ? ~b : b;  // Two's complement with the plus one below
        {carry_62, sum[62:0]} = {1'b0, a[62:0]} + {1'b0, b_in[62:0]} + {63'd0, sub};
        {carry_63, sum[63]} = {1'b0, a[63]} + {1'b0, b_in[63]} + {1'b0, carry_62};
    end

    assign sign     = sum[63];
    assign overflow = carry_63 ^ carry_62;  // Carries into and out of the sign bit differ

    // Reads as borrow when subtracting, i.e. unsigned a below b
    assign carry = carry_63 ^ sub;

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
`default_nettype none
`timescale 1ns/1ps

module alu (
    input  exu_pkg::xlen_t     operand_a,
    input  exu_pkg::xlen_t     operand_b,
    input  exu_pkg::alu_ctrl_t alu_ctrl,
    output exu_pkg::xlen_t     result,
    output logic               zero
);
    import exu_pkg::*;

    logic       sub_en;
    logic       arith;
    logic       word;
    xlen_t      sum;
    logic       carry;
    logic       sign;
    logic       overflow;
    logic [5:0] shamt;
    xlen_t      shift_src;
    xlen_t      shift_left;
    xlen_t      shift_right;
    xlen_t      raw;

    assign sub_en = alu_ctrl[3] | alu_ctrl[1];  // Compares need the difference too
    assign arith  = alu_ctrl[3];
    assign word   = alu_ctrl[4];

    alu_adder i_alu_adder (
        .a        (operand_a),
        .b        (operand_b),
        .sub      (sub_en),
        .sum      (sum),
        .carry    (carry),
        .sign     (sign),
        .overflow (overflow)
    );

    // Word shifts only look at the low five bits of b
    assign shamt = word ? {1'b0, operand_b[4:0]} : operand_b[5:0];

    // For word right shifts the low half is first extended, zero or sign as needed
    assign shift_src = word ? {{32{arith & operand_a[31]}}, operand_a[31:0]} : operand_a;

    assign shift_left = operand_a << shamt;

    always_comb begin
        if (arith) begin
            shift_right = $signed(shift_src) >>> shamt;
        end else begin
            shift_right = shift_src >> shamt;
        end
    end

    always_comb begin
        case (alu_ctrl[2:0])
            3'd0: raw = sum;
            3'd1: raw = shift_left;
            3'd2: raw = {63'd0, sign ^ overflow};  // Signed less than
            3'd3: raw = {63'd0, carry};  // Unsigned less than from the borrow
            3'd4: raw = operand_a ^ operand_b;
            3'd5: raw = shift_right;
            3'd6: raw = operand_a | operand_b;
            default: raw = ({64{alu_ctrl[3]}} | operand_a) & operand_b;
        endcase
    end

    // Word results are sign-extended from bit 31
    assign result = word ? {{32{raw[31]}}, raw[31:0]} : raw;

    assign zero = ~|(operand_a ^ operand_b);

endmodule

`default_nettype wire

// ==== verilog/alu_ctrl_decode.sv ====
`default_nettype none
`timescale 1ns/1ps

module alu_ctrl_decode (
    input  exu_pkg::inst_t     inst,
    output exu_pkg::alu_ctrl_t alu_ctrl,
    output logic               src_a_pc,
    output logic               src_b_imm,
    output exu_pkg::xlen_t     imm,
    output exu_pkg::br_kind_e  br_kind,
    output exu_pkg::reg_addr_t rd_addr
);
    import exu_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_b5;
    logic       imm_alt;
    xlen_t      imm_i;
    xlen_t      imm_u;
    xlen_t      imm_b;
    xlen_t      imm_j;

    // funct3 lines up with the ALU operation field
    function automatic alu_ctrl_t op_ctrl(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0: op_ctrl = alt ? ALU_SUB : ALU_ADD;
            3'd1: op_ctrl = ALU_SLL;
            3'd2: op_ctrl = ALU_SLT;
            3'd3: op_ctrl = ALU_SLTU;
            3'd4: op_ctrl = ALU_XOR;
            3'd5: op_ctrl = alt ? ALU_SRA : ALU_SRL;
            3'd6: op_ctrl = ALU_OR;
            default: op_ctrl = ALU_AND;
        endcase
    endfunction

    assign opcode    = inst[6:0];
    assign funct3    = inst[14:12];
    assign funct7_b5 = inst[30];
    assign imm_alt   = funct7_b5 && (funct3 == 3'd5);  // There is no subtract immediate

    assign imm_i = {{52{inst[31]}}, inst[31:20]};
    assign imm_u = {{32{inst[31]}}, inst[31:12], 12'd0};
    assign imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        alu_ctrl  = ALU_ADD;
        src_a_pc  = 1'b0;
        src_b_imm = 1'b0;
        imm       = imm_i;
        br_kind   = BR_NONE;
        rd_addr   = inst[11:7];
        case (opcode)
            OPC_OP: alu_ctrl = op_ctrl(funct3, funct7_b5);
            OPC_OP_IMM: begin
                alu_ctrl  = op_ctrl(funct3, imm_alt);
                src_b_imm = 1'b1;
            end
            OPC_OP_32: alu_ctrl = op_ctrl(funct3, funct7_b5) | ALU_W_BIT;
            OPC_OP_IMM_32: begin
                alu_ctrl  = op_ctrl(funct3, imm_alt) | ALU_W_BIT;
                src_b_imm = 1'b1;
            end
            OPC_LUI: begin
                alu_ctrl  = ALU_PASSB;
                src_b_imm = 1'b1;
                imm       = imm_u;
            end
            OPC_AUIPC: begin
                src_a_pc  = 1'b1;
                src_b_imm = 1'b1;
                imm       = imm_u;
            end
            OPC_BRANCH: begin
                imm     = imm_b;
                rd_addr = '0;  // Branches write nothing back
                case (funct3)
                    3'd0: {alu_ctrl, br_kind} = {ALU_SUB, BR_EQ};
                    3'd1: {alu_ctrl, br_kind} = {ALU_SUB, BR_NE};
                    3'd4: {alu_ctrl, br_kind} = {ALU_SLT, BR_LT};
                    3'd5: {alu_ctrl, br_kind} = {ALU_SLT, BR_GE};
                    3'd6: {alu_ctrl, br_kind} = {ALU_SLTU, BR_LTU};
                    3'd7: {alu_ctrl, br_kind} = {ALU_SLTU, BR_GEU};
                    default: br_kind = BR_NONE;
                endcase
            end
            OPC_JAL: begin
                imm     = imm_j;
                br_kind = BR_JAL;
            end
            OPC_JALR: br_kind = BR_JALR;
            default: rd_addr = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/branch_unit.sv ====
`default_nettype none
`timescale 1ns/1ps

module branch_unit (
    input  exu_pkg::br_kind_e br_kind,
    input  exu_pkg::xlen_t    pc,
    input  exu_pkg::xlen_t    rs1_data,
    input  exu_pkg::xlen_t    imm,
    input  logic              less,
    input  logic              zero,
    output logic              branch_taken,
    output exu_pkg::xlen_t    branch_target,
    output exu_pkg::xlen_t    link,
    output logic              link_sel
);
    import exu_pkg::*;

    logic  is_jalr;
    xlen_t target_base;
    xlen_t target_sum;

    always_comb begin
        case (br_kind)
            BR_EQ: branch_taken = zero;
            BR_NE: branch_taken = ~zero;
            BR_LT, BR_LTU: branch_taken = less;  // ALU already chose signed or unsigned
            BR_GE, BR_GEU: branch_taken = ~less;
            BR_JAL, BR_JALR: branch_taken = 1'b1;
            default: branch_taken = 1'b0;
        endcase
    end

    assign is_jalr     = br_kind == BR_JALR;
    assign target_base = is_jalr ? rs1_data : pc;
    assign target_sum  = target_base + imm;

    // JALR drops the low bit of its target
    assign branch_target = {target_sum[63:1], target_sum[0] & ~is_jalr};

    assign link     = pc + 64'd4;
    assign link_sel = (br_kind == BR_JAL) || is_jalr;

endmodule

`default_nettype wire

// ==== verilog/exu.sv ====
`default_nettype none
`timescale 1ns/1ps

module exu (
    input  logic                clock,
    input  logic                reset,
    input  logic                in_valid,
    input  exu_pkg::inst_t      inst,
    input  exu_pkg::xlen_t      pc,
    input  exu_pkg::xlen_t      rs1_data,
    input  exu_pkg::xlen_t      rs2_data,
    output logic                out_valid,
    output exu_pkg::xlen_t      rd_data,
    output exu_pkg::reg_addr_t  rd_addr,
    output logic                branch_taken,
    output exu_pkg::xlen_t      branch_target
);
    import exu_pkg::*;

    alu_ctrl_t alu_ctrl;
    logic      src_a_pc;
    logic      src_b_imm;
    xlen_t     imm;
    br_kind_e  br_kind;
    reg_addr_t dec_rd_addr;
    xlen_t     operand_a;
    xlen_t     operand_b;
    xlen_t     alu_result;
    logic      alu_zero;
    logic      next_taken;
    xlen_t     next_target;
    xlen_t     link;
    logic      link_sel;

    alu_ctrl_decode i_alu_ctrl_decode (
        .inst      (inst),
        .alu_ctrl  (alu_ctrl),
        .src_a_pc  (src_a_pc),
        .src_b_imm (src_b_imm),
        .imm       (imm),
        .br_kind   (br_kind),
        .rd_addr   (dec_rd_addr)
    );

    assign operand_a = src_a_pc ? pc : rs1_data;
    assign operand_b = src_b_imm ? imm : rs2_data;

    alu i_alu (
        .operand_a (operand_a),
        .operand_b (operand_b),
        .alu_ctrl  (alu_ctrl),
        .result    (alu_result),
        .zero      (alu_zero)
    );

    branch_unit i_branch_unit (
        .br_kind       (br_kind),
        .pc            (pc),
        .rs1_data      (rs1_data),
        .imm           (imm),
        .less          (alu_result[0]),  // Compare result when slt or sltu was chosen
        .zero          (alu_zero),
        .branch_taken  (next_taken),
        .branch_target (next_target),
        .link          (link),
        .link_sel      (link_sel)
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid    <= 1'b0;
            branch_taken <= 1'b0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                branch_taken <= next_taken;
            end
        end
    end

    // Results hold until the next accepted instruction
    always_ff @(posedge clock) begin
        if (in_valid) begin
            rd_data       <= link_sel ? link : alu_result;
            rd_addr       <= dec_rd_addr;
            branch_target <= next_target;
        end
    end

endmodule

`default_nettype wire

// ==== bench/exu_chk.sv ====
`default_nettype none
`timescale 1ns/1ps

module exu_chk (
    input wire logic clock,
    input wire logic reset,
    input wire logic in_valid,
    input wire logic out_valid,
    input wire logic branch_taken
);

    // One cycle of latency, every accepted instruction gives one result
    valid_follows_in: assert property (
        @(posedge clock) disable iff (reset)
        !$past(reset) |-> (out_valid == $past(in_valid))
    ) else $error("out_valid is not in_valid delayed by one cycle");

    reset_clears_outputs: assert property (
        @(posedge clock)
        $past(reset) |-> (!out_valid && !branch_taken)
    ) else $error("out_valid or branch_taken high in the cycle after reset");

    // Two accepted instructions in a row give two results in a row
    burst_results: assert property (
        @(posedge clock) disable iff (reset)
        (in_valid && $past(in_valid) && !$past(reset)) |=> (out_valid && $past(out_valid))
    ) else $error("back-to-back instructions did not each produce a result");

endmodule

`default_nettype wire

// ==== bench/exu_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module exu_tb;
    import exu_pkg::*;

    localparam int CLK_PERIOD      = 8;
    localparam int NUM_INST        = 600;
    localparam int WATCHDOG_CYCLES = NUM_INST * 20 + 100;

    typedef struct packed {
        xlen_t     rd_data;
        reg_addr_t rd_addr;
        logic      taken;
        xlen_t     target;
        logic      check_rd;
        logic      check_target;
    } result_t;

    logic      clock;
    logic      reset;
    logic      in_valid;
    inst_t     inst;
    xlen_t     pc;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    logic      out_valid;
    xlen_t     rd_data;
    reg_addr_t rd_addr;
    logic      branch_taken;
    xlen_t     branch_target;

    int        seed = 32'h9b91;
    int        issued;
    logic      have_last;
    result_t   last_result;
    result_t   expected_q[$];

    exu i_exu (
        .clock         (clock),
        .reset         (reset),
        .in_valid      (in_valid),
        .inst          (inst),
        .pc            (pc),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .out_valid     (out_valid),
        .rd_data       (rd_data),
        .rd_addr       (rd_addr),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    bind exu exu_chk i_exu_chk (
        .clock        (clock),
        .reset        (reset),
        .in_valid     (in_valid),
        .out_valid    (out_valid),
        .branch_taken (branch_taken)
    );

    initial clock = 1'b0;
    always #(CLK_PERIOD / 2) clock = ~clock;

    function automatic xlen_t sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    function automatic xlen_t alu64(input logic [2:0] f3, input logic sub, input logic sra,
                                    input xlen_t x, input xlen_t y);
        logic signed [63:0] sx;
        sx = x;
        case (f3)
            3'd0: return sub ? x - y : x + y;
            3'd1: return x << y[5:0];
            3'd2: return {63'd0, $signed(x) < $signed(y)};
            3'd3: return {63'd0, x < y};
            3'd4: return x ^ y;
            3'd5: begin
                if (sra) begin
                    sx = sx >>> y[5:0];
                    return sx;
                end
                return x >> y[5:0];
            end
            3'd6: return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic xlen_t alu32(input logic [2:0] f3, input logic sub, input logic sra,
                                    input logic [31:0] x, input logic [31:0] y);
        logic signed [31:0] sx;
        sx = x;
        if (f3 == 3'd1) return sext32(x << y[4:0]);
        if (f3 == 3'd5) begin
            sx = sx >>> y[4:0];
            return sra ? sext32(sx) : sext32(x >> y[4:0]);
        end
        return sub ? sext32(x - y) : sext32(x + y);
    endfunction

    function automatic result_t model(input inst_t i, input xlen_t p, input xlen_t a,
                                      input xlen_t b);
        result_t res;
        xlen_t   imm_i;
        xlen_t   imm_u;
        xlen_t   imm_b;
        xlen_t   imm_j;
        imm_i = {{52{i[31]}}, i[31:20]};
        imm_u = {{32{i[31]}}, i[31:12], 12'd0};
        imm_b = {{52{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
        imm_j = {{44{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
        res = '{rd_data: '0, rd_addr: i[11:7], taken: 1'b0, target: '0,
                check_rd: 1'b1, check_target: 1'b0};
        case (i[6:0])
            OPC_OP: res.rd_data = alu64(i[14:12], i[30], i[30], a, b);
            OPC_OP_IMM: res.rd_data = alu64(i[14:12], 1'b0, i[30], a, imm_i);
            OPC_OP_32: res.rd_data = alu32(i[14:12], i[30], i[30], a[31:0], b[31:0]);
            OPC_OP_IMM_32: res.rd_data = alu32(i[14:12], 1'b0, i[30], a[31:0], imm_i[31:0]);
            OPC_LUI: res.rd_data = imm_u;
            OPC_AUIPC: res.rd_data = p + imm_u;
            OPC_BRANCH: begin
                res.check_rd     = 1'b0;
                res.rd_addr      = '0;
                res.check_target = 1'b1;
                res.target       = p + imm_b;
                case (i[14:12])
                    3'd0: res.taken = a == b;
                    3'd1: res.taken = a != b;
                    3'd4: res.taken = $signed(a) < $signed(b);
                    3'd5: res.taken = $signed(a) >= $signed(b);
                    3'd6: res.taken = a < b;
                    default: res.taken = a >= b;
                endcase
            end
            OPC_JAL: res = '{p + 64'd4, i[11:7], 1'b1, p + imm_j, 1'b1, 1'b1};
            OPC_JALR: res = '{p + 64'd4, i[11:7], 1'b1, (a + imm_i) & ~64'd1, 1'b1, 1'b1};
            default: res.rd_addr = '0;
        endcase
        return res;
    endfunction

    function automatic xlen_t pick_operand();
        logic [31:0] r;
        r = $random(seed);
        case (r[2:0])
            3'd0: return 64'h8000_0000_0000_0000;  // Most negative value
            3'd1: return 64'h0000_0000_7fff_ffff;  // Word add overflows past bit 31
            3'd2: return '1;
            3'd3: return {56'd0, r[15:8]};
            default: return {$random(seed), $random(seed)};
        endcase
    endfunction

    function automatic inst_t random_inst();
        logic [31:0] r;
        logic [31:0] s;
        logic [2:0]  f3w;
        logic        alt;
        r   = $random(seed);
        s   = $random(seed);
        alt = r[22];
        f3w = (r[20:19] == 2'd0) ? 3'd0 : (r[20:19] == 2'd1) ? 3'd1 : 3'd5;
        case (r[3:0])
            4'd3, 4'd4: begin
                if (r[20:19] == 2'd1) begin
                    return {1'b0, alt & r[21], 4'd0, s[5:0], r[13:9], r[21], 2'b01, r[8:4],
                            OPC_OP_IMM};  // Shift immediate forms
                end
                return {s[31:20], r[13:9], r[21:19], r[8:4], OPC_OP_IMM};
            end
            4'd5: return {1'b0, alt & (f3w != 3'd1), 5'd0, r[18:14], r[13:9], f3w, r[8:4],
                          OPC_OP_32};
            4'd6: begin
                if (f3w == 3'd0) return {s[31:20], r[13:9], f3w, r[8:4], OPC_OP_IMM_32};
                return {1'b0, alt & f3w[2], 5'd0, s[4:0], r[13:9], f3w, r[8:4],
                        OPC_OP_IMM_32};
            end
            4'd7: return {s[31:12], r[8:4], OPC_LUI};
            4'd8: return {s[31:12], r[8:4], OPC_AUIPC};
            4'd9, 4'd10, 4'd11: return {s[31:25], r[18:14], r[13:9],
                                        r[21] | r[20], r[20:19], s[11:7], OPC_BRANCH};
            4'd12: return {s[31:12], r[8:4], OPC_JAL};
            4'd13: return {s[31:20], r[13:9], 3'd0, r[8:4], OPC_JALR};
            default: return {1'b0, alt & (r[21:19] == 3'd0 || r[21:19] == 3'd5), 5'd0,
                             r[18:14], r[13:9], r[21:19], r[8:4], OPC_OP};
        endcase
    endfunction

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "Run stopped");
    endtask

    task automatic compare_value(input string name, input xlen_t expected, input xlen_t actual);
        assert (expected === actual) else begin
            $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, expected, actual);
            stop_run("Output value mismatch");
        end
    endtask

    task automatic compare_result(input result_t r);
        compare_value("rd_addr", {59'd0, r.rd_addr}, {59'd0, rd_addr});
        compare_value("branch_taken", {63'd0, r.taken}, {63'd0, branch_taken});
        if (r.check_rd) compare_value("rd_data", r.rd_data, rd_data);
        if (r.check_target) compare_value("branch_target", r.target, branch_target);
    endtask

    // Sampled on the falling edge, before new inputs are driven
    task automatic check_outputs();
        if (out_valid) begin
            assert (expected_q.size() != 0) else stop_run("out_valid with no instruction issued");
            last_result = expected_q.pop_front();
            have_last   = 1'b1;
            compare_result(last_result);
        end else begin
            assert (expected_q.size() == 0) else stop_run("no result one cycle after in_valid");
            if (have_last) compare_result(last_result);  // Outputs hold between results
        end
    endtask

    task automatic drive_next();
        logic [31:0] r;
        r        = $random(seed);
        in_valid = r[1:0] != 2'd0;  // Mostly bursts, with gaps
        inst     = random_inst();
        pc       = {$random(seed), $random(seed)} & ~64'd3;
        rs1_data = pick_operand();
        rs2_data = r[4] ? rs1_data : pick_operand();
        if (in_valid) begin
            expected_q.push_back(model(inst, pc, rs1_data, rs2_data));
            issued = issued + 1;
        end
    endtask

    initial begin
        reset     = 1'b1;
        in_valid  = 1'b0;
        inst      = '0;
        pc        = '0;
        rs1_data  = '0;
        rs2_data  = '0;
        issued    = 0;
        have_last = 1'b0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        while (issued < NUM_INST) begin
            @(negedge clock);
            check_outputs();
            drive_next();
        end
        @(negedge clock);
        check_outputs();
        in_valid = 1'b0;
        @(negedge clock);
        check_outputs();
        if (expected_q.size() == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("Results are still pending at the end of the run");
            $display("TEST FAIL");
            $fatal(1, "Pending results");
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        stop_run("Watchdog expired before all results were checked");
    end

endmodule

`default_nettype wire

// ==== compile.f ====
verilog/exu_pkg.sv
verilog/alu_adder.sv
verilog/alu.sv
verilog/alu_ctrl_decode.sv
verilog/branch_unit.sv
verilog/exu.sv
bench/exu_chk.sv
bench/exu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := exu_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

SRCS := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
